// File: filelist.f
logic/reporter_pkg.sv
logic/count_if.sv
logic/btn_debouncer.sv
logic/decimal_counter.sv
logic/message_sender.sv
logic/uart_tx.sv
logic/press_reporter.sv
verification/tb_press_reporter.sv

// File: run_sim.sh
#!/bin/sh
# Builds the press reporter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_press_reporter \
    -Mdir obj_dir \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_press_reporter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
    echo "Simulation log has no result line"
    exit 1
fi
exit 0

// File: verification/tb_press_reporter.sv
/*
 * Press reporter testbench
 * Presses the button, decodes the UART text and checks the press count
 */
module tb_press_reporter;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS   = reporter_pkg::CLKS_PER_BIT;
    localparam int BYTE_CLKS  = 10 * BIT_CLKS + 10;
    localparam int MAX_BYTES  = reporter_pkg::HDR_LEN + reporter_pkg::NUM_DIGITS + 1;
    localparam int QUIET_CLKS = 20 * BIT_CLKS;
    // Debounce delay plus a couple of bit times to reach the first start bit
    localparam int FIRST_CLKS = 4 * reporter_pkg::DEBOUNCE_CYCLES + 2 * BIT_CLKS;
    // Hold, release, gap and settle around one message
    localparam int PRESS_CLKS = 4 * BIT_CLKS;
    // Twelve messages and three quiet windows, doubled
    localparam int WATCHDOG_CLKS =
        2 * (12 * (MAX_BYTES * BYTE_CLKS + PRESS_CLKS) + 3 * QUIET_CLKS);

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 btn;
    logic                 tx;
    reporter_pkg::count_t press_count;

    int                   errors = 0;
    logic [31:0]          lfsr_state = 32'hc977_5085;
    reporter_pkg::count_t model_count = '0;
    reporter_pkg::byte_t  rx_msg[$];

    press_reporter dut0 (
        .clk         (clk),
        .rst         (rst),
        .btn         (btn),
        .tx          (tx),
        .press_count (press_count)
    );

    always #5 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    // Galois LFSR, one step per bit taken
    function automatic int unsigned take_bits(input int n);
        int unsigned value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic int random_hold();
        return reporter_pkg::DEBOUNCE_CYCLES + 6 + int'(take_bits(5));
    endfunction

    task automatic check_byte(input string name, input reporter_pkg::byte_t exp,
                              input reporter_pkg::byte_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected 8'h%02h got 8'h%02h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input reporter_pkg::count_t exp,
                               input reporter_pkg::count_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic press_button(input int hold);
        @(posedge clk);
        btn <= 1'b1;
        repeat (hold) @(posedge clk);
        btn <= 1'b0;
        // Let the release settle as well
        repeat (reporter_pkg::DEBOUNCE_CYCLES + 6) @(posedge clk);
    endtask

    // --------------------
    // UART decoder
    // --------------------
    task automatic receive_byte(input int timeout_clks, output reporter_pkg::byte_t data,
                                output logic found);
        int waited;
        waited = 0;
        data   = '0;
        found  = 1'b0;
        while (tx !== 1'b0 && waited < timeout_clks) begin
            @(negedge clk);
            waited++;
        end
        if (tx === 1'b0) begin
            found = 1'b1;
            // Middle of the start bit
            wait_clocks(BIT_CLKS / 2);
            check_bit("tx start bit", 1'b0, tx);
            for (int i = 0; i < reporter_pkg::BYTE_W; i++) begin
                wait_clocks(BIT_CLKS);
                data[i] = tx;
            end
            wait_clocks(BIT_CLKS);
            check_bit("tx stop bit", 1'b1, tx);
        end
    endtask

    task automatic receive_message(input int first_timeout);
        reporter_pkg::byte_t data;
        logic                found;
        logic                got_lf;
        got_lf = 1'b0;
        rx_msg.delete();
        while (!got_lf && rx_msg.size() < MAX_BYTES) begin
            receive_byte(rx_msg.size() == 0 ? first_timeout : 2 * BIT_CLKS, data, found);
            if (!found) begin
                break;
            end
            rx_msg.push_back(data);
            got_lf = (data == 8'h0A);
        end
        if (!got_lf) begin
            errors++;
            $display("No line feed at %0t, message stopped after %0d bytes",
                     $time, rx_msg.size());
        end
        // Sender is back in idle before the next press
        wait_clocks(BIT_CLKS);
    endtask

    task automatic check_message(input reporter_pkg::count_t n);
        string               text;
        reporter_pkg::byte_t expected[$];
        text = $sformatf("BTN %0d", n);
        for (int i = 0; i < text.len(); i++) begin
            expected.push_back(reporter_pkg::byte_t'(text[i]));
        end
        expected.push_back(8'h0A);
        if (rx_msg.size() != expected.size()) begin
            errors++;
            $display("Message for count %0d has %0d bytes instead of %0d",
                     n, rx_msg.size(), expected.size());
        end
        for (int i = 0; i < expected.size() && i < rx_msg.size(); i++) begin
            check_byte($sformatf("tx byte %0d", i), expected[i], rx_msg[i]);
        end
        check_count("press_count", n, press_count);
    endtask

    task automatic expect_quiet(input string what);
        reporter_pkg::byte_t data;
        logic                found;
        receive_byte(QUIET_CLKS, data, found);
        if (found) begin
            errors++;
            $display("Unexpected frame on tx %s at %0t", what, $time);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_idle();
        for (int i = 0; i < 2 * BIT_CLKS * 10; i++) begin
            @(negedge clk);
            if (tx !== 1'b1 || press_count !== '0) begin
                check_bit("tx", 1'b1, tx);
                check_count("press_count", '0, press_count);
                break;
            end
        end
    endtask

    task automatic test_single_press();
        model_count++;
        fork
            press_button(random_hold());
            receive_message(FIRST_CLKS);
        join
        check_message(model_count);
    endtask

    task automatic test_short_glitch();
        @(posedge clk);
        btn <= 1'b1;
        repeat (reporter_pkg::DEBOUNCE_CYCLES - 4) @(posedge clk);
        btn <= 1'b0;
        expect_quiet("after a short glitch");
        check_count("press_count", model_count, press_count);
    endtask

    task automatic test_press_while_busy();
        model_count++;
        fork
            begin
                press_button(random_hold());
                repeat (BIT_CLKS + int'(take_bits(6))) @(posedge clk);
                press_button(random_hold());
            end
            receive_message(FIRST_CLKS);
        join
        check_message(model_count);
        expect_quiet("after a press during a message");
        check_count("press_count", model_count, press_count);
    endtask

    task automatic test_count_to_twelve();
        while (model_count < 16'd12) begin
            repeat (int'(take_bits(6))) @(posedge clk);
            model_count++;
            fork
                press_button(random_hold());
                receive_message(FIRST_CLKS);
            join
            check_message(model_count);
        end
    endtask

    initial begin
        rst = 1'b1;
        btn = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_reset_idle();
        test_single_press();
        test_short_glitch();
        test_press_while_busy();
        test_count_to_twelve();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Watchdog expired after %0d clocks, errors: %0d", WATCHDOG_CLKS, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: logic/press_reporter.sv
/*
 * Press reporter top level
 * Debounced button presses are counted and reported as UART text
 */
module press_reporter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 btn,
    output logic                 tx,
    output reporter_pkg::count_t press_count
);

    logic                pressed;
    reporter_pkg::byte_t tx_data;
    logic                tx_start;
    logic                tx_busy;

    count_if cnt_bus ();

    btn_debouncer u_debouncer (
        .clk     (clk),
        .rst     (rst),
        .btn     (btn),
        .pressed (pressed)
    );

    decimal_counter u_counter (
        .clk (clk),
        .rst (rst),
        .cnt (cnt_bus.counter)
    );

    // --------------------
    // Message path
    // --------------------
    message_sender u_sender (
        .clk      (clk),
        .rst      (rst),
        .pressed  (pressed),
        .cnt      (cnt_bus.sender),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    assign press_count = cnt_bus.count;

endmodule

// File: logic/uart_tx.sv
/*
 * UART transmitter, 8N1
 * Start bit, eight data bits LSB first and a stop bit at CLKS_PER_BIT each
 */
module uart_tx (
    input  logic                clk,
    input  logic                rst,
    input  reporter_pkg::byte_t tx_data,
    input  logic                tx_start,
    output logic                tx_busy,
    output logic                tx
);

    localparam int BAUD_W = $clog2(reporter_pkg::CLKS_PER_BIT);
    localparam logic [BAUD_W-1:0] BAUD_RELOAD = BAUD_W'(reporter_pkg::CLKS_PER_BIT - 1);

    logic [BAUD_W-1:0] baud_cnt;
    logic              baud_tick;
    logic [9:0]        frame;
    logic [3:0]        bit_idx;

    // --------------------
    // Bit timing
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            baud_cnt <= BAUD_RELOAD;
        end else if (!tx_busy || baud_cnt == '0) begin
            baud_cnt <= BAUD_RELOAD;
        end else begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    assign baud_tick = tx_busy && (baud_cnt == '0);

    // --------------------
    // Frame shifter
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy <= 1'b0;
            frame   <= '1;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                frame   <= {1'b1, tx_data, 1'b0};
                bit_idx <= '0;
            end
        end else if (baud_tick) begin
            // Ones shift in behind, so the line rests high
            frame   <= {1'b1, frame[9:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;
            end
        end
    end

    assign tx = frame[0];

    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (rst) tx_start |-> !tx_busy
    );

endmodule

// File: logic/message_sender.sv
/*
 * Message sender
 * Counts a press and hands "BTN <count>\n" byte by byte to the UART
 */
module message_sender (
    input  logic                clk,
    input  logic                rst,
    input  logic                pressed,
    count_if.sender             cnt,
    output reporter_pkg::byte_t tx_data,
    output logic                tx_start,
    input  logic                tx_busy
);

    typedef enum logic {
        IDLE,
        SENDING
    } state_t;

    localparam int IDX_W = $clog2(reporter_pkg::HDR_LEN + reporter_pkg::NUM_DIGITS + 2);

    state_t                   state;
    logic [IDX_W-1:0]         idx;
    logic                     waiting;
    logic [IDX_W-1:0]         last_idx;
    reporter_pkg::digit_idx_t digit_pos;

    // Presses outside idle are dropped
    assign cnt.advance = (state == IDLE) && pressed;

    // Line feed follows lead+1 digits
    assign last_idx  = IDX_W'(reporter_pkg::HDR_LEN) + IDX_W'(cnt.lead) + 1'b1;
    // Most significant digit goes first
    assign digit_pos = cnt.lead
                     - reporter_pkg::digit_idx_t'(idx - IDX_W'(reporter_pkg::HDR_LEN));

    // --------------------
    // Byte select
    // --------------------
    always_comb begin
        case (idx)
            IDX_W'(0): tx_data = reporter_pkg::HDR_B;
            IDX_W'(1): tx_data = reporter_pkg::HDR_T;
            IDX_W'(2): tx_data = reporter_pkg::HDR_N;
            IDX_W'(3): tx_data = reporter_pkg::HDR_SPACE;
            default: begin
                if (idx < last_idx) begin
                    tx_data = reporter_pkg::ASCII_ZERO
                            + reporter_pkg::byte_t'(cnt.digits[digit_pos]);
                end else begin
                    tx_data = reporter_pkg::ASCII_LF;
                end
            end
        endcase
    end

    // --------------------
    // Control FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            idx      <= '0;
            waiting  <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (pressed) begin
                        state   <= SENDING;
                        idx     <= '0;
                        waiting <= 1'b0;
                    end
                end
                SENDING: begin
                    if (waiting) begin
                        // Byte taken once busy rises
                        if (tx_busy) begin
                            waiting <= 1'b0;
                            idx     <= idx + 1'b1;
                        end
                    end else if (!tx_busy) begin
                        if (idx > last_idx) begin
                            state <= IDLE;
                        end else begin
                            tx_start <= 1'b1;
                            waiting  <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/decimal_counter.sv
/*
 * Press counter
 * Keeps a wrapping binary count and a five-digit BCD copy with its lead digit
 */
module decimal_counter (
    input  logic    clk,
    input  logic    rst,
    count_if.counter cnt
);

    reporter_pkg::digits_t    next_digits;
    reporter_pkg::digit_idx_t next_lead;
    logic                     carry;

    function automatic logic digits_valid(input reporter_pkg::digits_t d);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < reporter_pkg::NUM_DIGITS; i++) begin
            if (d[i] > 4'd9) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // --------------------
    // BCD increment
    // --------------------
    always_comb begin
        carry = 1'b1;
        for (int i = 0; i < reporter_pkg::NUM_DIGITS; i++) begin
            if (carry && cnt.digits[i] == 4'd9) begin
                next_digits[i] = '0;
            end else begin
                next_digits[i] = cnt.digits[i] + reporter_pkg::bcd_digit_t'(carry);
                carry          = 1'b0;
            end
        end
    end

    // Highest non-zero digit wins
    always_comb begin
        next_lead = '0;
        for (int i = 0; i < reporter_pkg::NUM_DIGITS; i++) begin
            if (next_digits[i] != '0) begin
                next_lead = reporter_pkg::digit_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt.count  <= '0;
            cnt.digits <= '0;
            cnt.lead   <= '0;
        end else if (cnt.advance) begin
            cnt.count  <= cnt.count + 1'b1;
            cnt.digits <= next_digits;
            cnt.lead   <= next_lead;
        end
    end

    a_digits_bcd: assert property (
        @(posedge clk) disable iff (rst) digits_valid(cnt.digits)
    );

endmodule

// File: logic/btn_debouncer.sv
/*
 * Button debouncer
 * Synchronizes the button, filters short glitches and pulses once per press
 */
module btn_debouncer (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic pressed
);

    localparam int CNT_W = $clog2(reporter_pkg::DEBOUNCE_CYCLES);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(reporter_pkg::DEBOUNCE_CYCLES - 1);

    logic             btn_clean;
    logic             sync_0;
    logic             sync_1;
    logic             debounced;
    logic             debounced_prev;
    logic [CNT_W-1:0] hold_cnt;

    // Unknown input counts as released
    assign btn_clean = (btn === 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0         <= 1'b0;
            sync_1         <= 1'b0;
            debounced      <= 1'b0;
            debounced_prev <= 1'b0;
            hold_cnt       <= '0;
            pressed        <= 1'b0;
        end else begin
            sync_0 <= btn_clean;
            sync_1 <= sync_0;

            // Level must differ for DEBOUNCE_CYCLES clocks in a row
            if (sync_1 == debounced) begin
                hold_cnt <= '0;
            end else if (hold_cnt == CNT_MAX) begin
                debounced <= sync_1;
                hold_cnt  <= '0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end

            // Rising edge of the filtered level
            debounced_prev <= debounced;
            pressed        <= debounced && !debounced_prev;
        end
    end

    // Single pulse that follows a released level held for a whole debounce window
    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
            pressed |-> !$past(pressed)
                     && !$past(debounced, reporter_pkg::DEBOUNCE_CYCLES + 1)
    );

endmodule

// File: logic/count_if.sv
/*
 * Press count link
 * Advance strobe from the sender, binary and BCD count back from the counter
 */
interface count_if;

    logic                    advance;
    reporter_pkg::count_t    count;
    reporter_pkg::digits_t   digits;
    // Highest non-zero digit, 0 for a zero count
    reporter_pkg::digit_idx_t lead;

    modport counter (
        input  advance,
        output count,
        output digits,
        output lead
    );

    modport sender (
        output advance,
        input  count,
        input  digits,
        input  lead
    );

endinterface

// File: logic/reporter_pkg.sv
/*
 * Press reporter shared definitions
 * Clock and baud rates, debounce length, message characters and digit types
 */
package reporter_pkg;

    // --------------------
    // Timing
    // --------------------
    localparam int CLOCK_HZ        = 12_000_000;
    localparam int BAUD            = 115_200;
    localparam int CLKS_PER_BIT    = CLOCK_HZ / BAUD;
    localparam int DEBOUNCE_CYCLES = 16;

    // --------------------
    // Widths
    // --------------------
    localparam int NUM_DIGITS = 5;
    localparam int BYTE_W     = 8;
    localparam int COUNT_W    = 16;

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [3:0]         bcd_digit_t;
    // Digit 0 is the least significant
    typedef bcd_digit_t [NUM_DIGITS-1:0] digits_t;
    typedef logic [2:0]         digit_idx_t;
    typedef logic [COUNT_W-1:0] count_t;

    // --------------------
    // Message characters
    // --------------------
    localparam byte_t HDR_B      = 8'h42;
    localparam byte_t HDR_T      = 8'h54;
    localparam byte_t HDR_N      = 8'h4E;
    localparam byte_t HDR_SPACE  = 8'h20;
    localparam byte_t ASCII_ZERO = 8'h30;
    localparam byte_t ASCII_LF   = 8'h0A;

    // "BTN " before the digits
    localparam int HDR_LEN = 4;

endpackage
